// File: design/blob_ranker.sv
`timescale 1ns/1ps

module blob_ranker import ccl_pkg::*; #(
    parameter int MAX_LABELS = ccl_pkg::MAX_LABELS,
    parameter int MIN_AREA = DEFAULT_MIN_AREA
) (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       rank_start,
    output label_t     rd_label,
    input  area_t      rd_area,
    input  sum_t       rd_sum_x,
    input  sum_t       rd_sum_y,
    output logic       rank_done,
    output area_t      area_out [3],
    output coord_t     com_x_out [3],
    output coord_t     com_y_out [3],
    output logic [1:0] blob_count_out
);

    typedef enum logic [1:0] {RK_IDLE, RK_SCAN, RK_DIV} rk_state_t;

    rk_state_t st;
    logic [1:0] pos;
    logic div_start, done_x, done_y, last;
    sum_t div_sx, div_sy;
    area_t div_area;
    coord_t q_x, q_y;

    assign last = (rd_label == label_t'(MAX_LABELS - 1));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            st <= RK_IDLE;
            rank_done <= 1'b0;
            div_start <= 1'b0;
        end else begin
            rank_done <= 1'b0;
            div_start <= 1'b0;
            case (st)
                RK_IDLE: begin
                    if (rank_start) begin
                        rd_label <= '0;
                        blob_count_out <= '0;
                        for (int i = 0; i < 3; i++) begin
                            area_out[i] <= '0;
                            com_x_out[i] <= '0;
                            com_y_out[i] <= '0;
                        end
                        st <= RK_SCAN;
                    end
                end
                RK_SCAN: begin
                    // strictly greater, so lower labels keep ties
                    if (rd_area >= area_t'(MIN_AREA) && rd_area > area_out[2]) begin
                        if (rd_area > area_out[0]) begin
                            pos <= 2'd0;
                            area_out[2] <= area_out[1];
                            com_x_out[2] <= com_x_out[1];
                            com_y_out[2] <= com_y_out[1];
                            area_out[1] <= area_out[0];
                            com_x_out[1] <= com_x_out[0];
                            com_y_out[1] <= com_y_out[0];
                            area_out[0] <= rd_area;
                        end else if (rd_area > area_out[1]) begin
                            pos <= 2'd1;
                            area_out[2] <= area_out[1];
                            com_x_out[2] <= com_x_out[1];
                            com_y_out[2] <= com_y_out[1];
                            area_out[1] <= rd_area;
                        end else begin
                            pos <= 2'd2;
                            area_out[2] <= rd_area;
                        end
                        if (blob_count_out != 2'd3) begin
                            blob_count_out <= blob_count_out + 1'b1;
                        end
                        div_sx <= rd_sum_x;
                        div_sy <= rd_sum_y;
                        div_area <= rd_area;
                        div_start <= 1'b1;
                        st <= RK_DIV;
                    end else if (last) begin
                        rank_done <= 1'b1;
                        st <= RK_IDLE;
                    end else begin
                        rd_label <= rd_label + 1'b1;
                    end
                end
                RK_DIV: begin
                    // same width dividers finish together
                    if (done_x && done_y) begin
                        com_x_out[pos] <= q_x;
                        com_y_out[pos] <= q_y;
                        if (last) begin
                            rank_done <= 1'b1;
                            st <= RK_IDLE;
                        end else begin
                            rd_label <= rd_label + 1'b1;
                            st <= RK_SCAN;
                        end
                    end
                end
                default: st <= RK_IDLE;
            endcase
        end
    end

    centroid_divider #(.DIVIDEND_W(SUM_W)) u_div_x (
        .clk_in (clk_in), .rst_in (rst_in), .start (div_start),
        .dividend (div_sx), .divisor (div_area), .done (done_x), .quotient (q_x)
    );

    centroid_divider #(.DIVIDEND_W(SUM_W)) u_div_y (
        .clk_in (clk_in), .rst_in (rst_in), .start (div_start),
        .dividend (div_sy), .divisor (div_area), .done (done_y), .quotient (q_y)
    );

endmodule

// File: design/blob_table.sv
`timescale 1ns/1ps

module blob_table import ccl_pkg::*; #(
    parameter int MAX_LABELS = ccl_pkg::MAX_LABELS
) (
    input  logic   clk_in,
    input  logic   rst_in,
    input  logic   acc_en,
    input  label_t acc_label,
    input  coord_t acc_x,
    input  coord_t acc_y,
    input  logic   fold_start,
    output label_t fold_label,
    input  label_t fold_root,
    output logic   fold_done,
    input  label_t rd_label,
    output area_t  rd_area,
    output sum_t   rd_sum_x,
    output sum_t   rd_sum_y
);

    area_t area_tab [MAX_LABELS];
    sum_t sx_tab [MAX_LABELS];
    sum_t sy_tab [MAX_LABELS];
    logic folding;

    assign rd_area = area_tab[rd_label];
    assign rd_sum_x = sx_tab[rd_label];
    assign rd_sum_y = sy_tab[rd_label];

    // top pulses reset at frame start, which also empties the tables
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            folding <= 1'b0;
            fold_done <= 1'b0;
            fold_label <= '0;
            for (int i = 0; i < MAX_LABELS; i++) begin
                area_tab[i] <= '0;
                sx_tab[i] <= '0;
                sy_tab[i] <= '0;
            end
        end else begin
            fold_done <= 1'b0;
            if (acc_en) begin
                area_tab[acc_label] <= area_tab[acc_label] + 1'b1;
                sx_tab[acc_label] <= sx_tab[acc_label] + SUM_W'(acc_x);
                sy_tab[acc_label] <= sy_tab[acc_label] + SUM_W'(acc_y);
            end
            if (fold_start) begin
                folding <= 1'b1;
                fold_label <= '0;
            end else if (folding) begin
                // roots sit below their members, so they are never moved again
                if (fold_root != fold_label) begin
                    area_tab[fold_root] <= area_tab[fold_root] + area_tab[fold_label];
                    sx_tab[fold_root] <= sx_tab[fold_root] + sx_tab[fold_label];
                    sy_tab[fold_root] <= sy_tab[fold_root] + sy_tab[fold_label];
                    area_tab[fold_label] <= '0;
                    sx_tab[fold_label] <= '0;
                    sy_tab[fold_label] <= '0;
                end
                if (fold_label == label_t'(MAX_LABELS - 1)) begin
                    folding <= 1'b0;
                    fold_done <= 1'b1;
                end else begin
                    fold_label <= fold_label + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/ccl_pkg.sv
package ccl_pkg;

    // default frame geometry
    parameter int FRAME_W = 32;
    parameter int FRAME_H = 24;
    // pixel address, log2 of pixel count
    parameter int PIX_W = $clog2(FRAME_W * FRAME_H);
    parameter int COORD_W = 6;

    // label table depth, label 0 means background
    parameter int MAX_LABELS = 64;
    parameter int LABEL_W = $clog2(MAX_LABELS);

    parameter int AREA_W = 16;
    parameter int SUM_W = 24;
    parameter int DEFAULT_MIN_AREA = 8;

    typedef logic [LABEL_W-1:0] label_t;
    typedef logic [AREA_W-1:0] area_t;
    typedef logic [SUM_W-1:0] sum_t;
    typedef logic [COORD_W-1:0] coord_t;

    // top level frame phases
    typedef enum logic [2:0] {
        PH_IDLE, PH_STORE, PH_SCAN, PH_FOLD, PH_RANK, PH_DONE
    } frame_phase_t;

endpackage

// File: design/ccl_top.sv
`timescale 1ns/1ps

module ccl_top import ccl_pkg::*; #(
    parameter int FRAME_W = ccl_pkg::FRAME_W,
    parameter int FRAME_H = ccl_pkg::FRAME_H,
    parameter int MAX_LABELS = ccl_pkg::MAX_LABELS,
    parameter int MIN_AREA = DEFAULT_MIN_AREA
) (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       new_frame_in,
    input  logic       valid_in,
    input  logic       mask_in,
    output logic       busy_out,
    output logic       valid_out,
    output area_t      area_out [3],
    output coord_t     com_x_out [3],
    output coord_t     com_y_out [3],
    output logic [1:0] blob_count_out
);

    frame_phase_t phase;
    logic [PIX_W-1:0] store_addr, mask_addr;
    logic mask_bit, frame_start, scan_start, scan_done, fold_start, fold_done;
    logic rank_start, rank_done, acc_en;
    label_t acc_label, fold_label, fold_root, rd_label;
    coord_t acc_x, acc_y;
    area_t rd_area;
    sum_t rd_sum_x, rd_sum_y;
    area_t rk_area [3];
    coord_t rk_cx [3], rk_cy [3];
    logic [1:0] rk_count;

    assign frame_start = (phase == PH_IDLE) && new_frame_in;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            phase <= PH_IDLE;
            busy_out <= 1'b0;
            valid_out <= 1'b0;
            scan_start <= 1'b0;
            fold_start <= 1'b0;
            rank_start <= 1'b0;
        end else begin
            valid_out <= 1'b0;
            scan_start <= 1'b0;
            fold_start <= 1'b0;
            rank_start <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (new_frame_in) begin
                        store_addr <= '0;
                        busy_out <= 1'b1;
                        phase <= PH_STORE;
                    end
                end
                PH_STORE: begin
                    if (valid_in) begin
                        store_addr <= store_addr + 1'b1;
                        if (store_addr == PIX_W'(FRAME_W * FRAME_H - 1)) begin
                            scan_start <= 1'b1;
                            phase <= PH_SCAN;
                        end
                    end
                end
                PH_SCAN: begin
                    if (scan_done) begin
                        fold_start <= 1'b1;
                        phase <= PH_FOLD;
                    end
                end
                PH_FOLD: begin
                    if (fold_done) begin
                        rank_start <= 1'b1;
                        phase <= PH_RANK;
                    end
                end
                PH_RANK: begin
                    // results held until the next frame's results
                    if (rank_done) begin
                        area_out <= rk_area;
                        com_x_out <= rk_cx;
                        com_y_out <= rk_cy;
                        blob_count_out <= rk_count;
                        phase <= PH_DONE;
                    end
                end
                PH_DONE: begin
                    valid_out <= 1'b1;
                    busy_out <= 1'b0;
                    phase <= PH_IDLE;
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // mask plane, only port a is read
    frame_ram #(.word_t(logic), .DEPTH(FRAME_W * FRAME_H)) u_mask_ram (
        .clk_in (clk_in), .we (valid_in && phase == PH_STORE),
        .waddr (store_addr), .wdata (mask_in),
        .raddr_a (mask_addr), .raddr_b (mask_addr),
        .rdata_a (mask_bit), .rdata_b ()
    );

    label_scan #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .MAX_LABELS(MAX_LABELS)) u_scan (
        .clk_in (clk_in), .rst_in (rst_in), .scan_start (scan_start),
        .mask_addr (mask_addr), .mask_bit (mask_bit),
        .acc_en (acc_en), .acc_label (acc_label), .acc_x (acc_x), .acc_y (acc_y),
        .scan_done (scan_done), .fold_label (fold_label), .fold_root (fold_root)
    );

    // tables empty at each frame start
    blob_table #(.MAX_LABELS(MAX_LABELS)) u_table (
        .clk_in (clk_in), .rst_in (rst_in || frame_start),
        .acc_en (acc_en), .acc_label (acc_label), .acc_x (acc_x), .acc_y (acc_y),
        .fold_start (fold_start), .fold_label (fold_label), .fold_root (fold_root),
        .fold_done (fold_done), .rd_label (rd_label), .rd_area (rd_area),
        .rd_sum_x (rd_sum_x), .rd_sum_y (rd_sum_y)
    );

    blob_ranker #(.MAX_LABELS(MAX_LABELS), .MIN_AREA(MIN_AREA)) u_ranker (
        .clk_in (clk_in), .rst_in (rst_in), .rank_start (rank_start),
        .rd_label (rd_label), .rd_area (rd_area), .rd_sum_x (rd_sum_x),
        .rd_sum_y (rd_sum_y), .rank_done (rank_done), .area_out (rk_area),
        .com_x_out (rk_cx), .com_y_out (rk_cy), .blob_count_out (rk_count)
    );

endmodule

// File: design/centroid_divider.sv
`timescale 1ns/1ps

module centroid_divider import ccl_pkg::*; #(
    parameter int DIVIDEND_W = SUM_W
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  start,
    input  logic [DIVIDEND_W-1:0] dividend,
    input  area_t                 divisor,
    output logic                  done,
    output coord_t                quotient
);

    logic [DIVIDEND_W-1:0] q, q_next;
    logic [AREA_W-1:0] rem, rem_next;
    logic [AREA_W:0] trial;
    area_t dvs;
    logic [$clog2(DIVIDEND_W+1)-1:0] cnt;
    logic busy;

    // shift in the next dividend bit, subtract if it fits
    always_comb begin
        trial = {rem, q[DIVIDEND_W-1]};
        if (trial >= {1'b0, dvs}) begin
            rem_next = AREA_W'(trial - {1'b0, dvs});
            q_next = {q[DIVIDEND_W-2:0], 1'b1};
        end else begin
            rem_next = trial[AREA_W-1:0];
            q_next = {q[DIVIDEND_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                q <= dividend;
                rem <= '0;
                dvs <= divisor;
                cnt <= '0;
                busy <= 1'b1;
            end else if (busy) begin
                q <= q_next;
                rem <= rem_next;
                cnt <= cnt + 1'b1;
                // last bit lands straight in the held quotient
                if (cnt == DIVIDEND_W - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    quotient <= q_next[COORD_W-1:0];
                end
            end
        end
    end

endmodule

// File: design/frame_ram.sv
`timescale 1ns/1ps

module frame_ram #(
    parameter type word_t = logic,
    parameter int DEPTH = 16
) (
    input  logic                     clk_in,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr_a,
    input  logic [$clog2(DEPTH)-1:0] raddr_b,
    output word_t                    rdata_a,
    output word_t                    rdata_b
);

    word_t mem [DEPTH];

    // one write port, two registered read ports
    always_ff @(posedge clk_in) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // read returns the old word on a same-address write
        rdata_a <= mem[raddr_a];
        rdata_b <= mem[raddr_b];
    end

endmodule

// File: design/label_scan.sv
`timescale 1ns/1ps

module label_scan import ccl_pkg::*; #(
    parameter int FRAME_W = ccl_pkg::FRAME_W,
    parameter int FRAME_H = ccl_pkg::FRAME_H,
    parameter int MAX_LABELS = ccl_pkg::MAX_LABELS
) (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             scan_start,
    output logic [PIX_W-1:0] mask_addr,
    input  logic             mask_bit,
    output logic             acc_en,
    output label_t           acc_label,
    output coord_t           acc_x,
    output coord_t           acc_y,
    output logic             scan_done,
    input  label_t           fold_label,
    output label_t           fold_root
);

    localparam label_t LAST_LABEL = label_t'(MAX_LABELS - 1);

    typedef enum logic [2:0] {
        LS_IDLE, LS_FETCH, LS_MASK, LS_NB2, LS_MERGE, LS_FIND, LS_ADV, LS_FLAT
    } ls_state_t;

    ls_state_t st;
    logic [PIX_W-1:0] p;
    coord_t x, y;
    label_t next_label, cur, ra, rb, flat_idx;
    // neighbour labels: w, nw, n, ne
    label_t nb [4];
    logic [1:0] k;
    label_t equiv [MAX_LABELS];

    logic [PIX_W-1:0] raddr_a, raddr_b;
    label_t rdata_a, rdata_b, w_l, ne_l, min_l, new_l;
    logic has_w, has_n, has_ne, lab_we;

    assign mask_addr = p;
    assign fold_root = equiv[fold_label];

    // frame edges count as unlabelled
    assign has_w = (x != 0);
    assign has_n = (y != 0);
    assign has_ne = has_n && (x != coord_t'(FRAME_W - 1));

    // first round nw and n, second round ne and w
    assign raddr_a = (st == LS_FETCH) ? PIX_W'(p - FRAME_W - 1) : PIX_W'(p - FRAME_W + 1);
    assign raddr_b = (st == LS_FETCH) ? PIX_W'(p - FRAME_W) : PIX_W'(p - 1);

    assign w_l = has_w ? rdata_b : '0;
    assign ne_l = has_ne ? rdata_a : '0;

    // smallest nonzero neighbour, else a fresh label
    always_comb begin
        min_l = '0;
        for (int i = 0; i < 4; i++) begin
            label_t c;
            c = (i == 0) ? w_l : (i == 3) ? ne_l : nb[i];
            if (c != 0 && (min_l == 0 || c < min_l)) begin
                min_l = c;
            end
        end
        new_l = (min_l != 0) ? min_l : next_label;
    end

    // background pixels get label 0 so old frames leave nothing behind
    assign lab_we = (st == LS_NB2) || (st == LS_MASK && !mask_bit);

    frame_ram #(.word_t(label_t), .DEPTH(FRAME_W * FRAME_H)) u_label_ram (
        .clk_in  (clk_in),
        .we      (lab_we),
        .waddr   (p),
        .wdata   ((st == LS_NB2) ? new_l : label_t'(0)),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            st <= LS_IDLE;
            acc_en <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            acc_en <= 1'b0;
            scan_done <= 1'b0;
            case (st)
                LS_IDLE: begin
                    if (scan_start) begin
                        p <= '0;
                        x <= '0;
                        y <= '0;
                        next_label <= label_t'(1);
                        for (int i = 0; i < MAX_LABELS; i++) begin
                            equiv[i] <= label_t'(i);
                        end
                        st <= LS_FETCH;
                    end
                end
                LS_FETCH: st <= LS_MASK;
                LS_MASK: begin
                    nb[1] <= (has_n && has_w) ? rdata_a : '0;
                    nb[2] <= has_n ? rdata_b : '0;
                    st <= mask_bit ? LS_NB2 : LS_ADV;
                end
                LS_NB2: begin
                    cur <= new_l;
                    nb[0] <= w_l;
                    nb[3] <= ne_l;
                    // labels saturate at the last entry
                    if (min_l == 0 && next_label != LAST_LABEL) begin
                        next_label <= next_label + 1'b1;
                    end
                    acc_en <= 1'b1;
                    acc_label <= new_l;
                    acc_x <= x;
                    acc_y <= y;
                    k <= '0;
                    st <= LS_MERGE;
                end
                LS_MERGE: begin
                    if (nb[k] != 0 && nb[k] != cur) begin
                        ra <= nb[k];
                        rb <= cur;
                        st <= LS_FIND;
                    end else if (k == 2'd3) begin
                        st <= LS_ADV;
                    end else begin
                        k <= k + 1'b1;
                    end
                end
                LS_FIND: begin
                    // walk both pointers to their roots
                    if (equiv[ra] != ra) begin
                        ra <= equiv[ra];
                    end
                    if (equiv[rb] != rb) begin
                        rb <= equiv[rb];
                    end
                    if (equiv[ra] == ra && equiv[rb] == rb) begin
                        // larger root points at smaller one
                        if (ra < rb) begin
                            equiv[rb] <= ra;
                        end else if (rb < ra) begin
                            equiv[ra] <= rb;
                        end
                        k <= k + 1'b1;
                        st <= (k == 2'd3) ? LS_ADV : LS_MERGE;
                    end
                end
                LS_ADV: begin
                    if (p == PIX_W'(FRAME_W * FRAME_H - 1)) begin
                        flat_idx <= label_t'(1);
                        st <= LS_FLAT;
                    end else begin
                        p <= p + 1'b1;
                        if (x == coord_t'(FRAME_W - 1)) begin
                            x <= '0;
                            y <= y + 1'b1;
                        end else begin
                            x <= x + 1'b1;
                        end
                        st <= LS_FETCH;
                    end
                end
                LS_FLAT: begin
                    // parents are always lower, so one ascending pass suffices
                    equiv[flat_idx] <= equiv[equiv[flat_idx]];
                    if (flat_idx == LAST_LABEL) begin
                        scan_done <= 1'b1;
                        st <= LS_IDLE;
                    end else begin
                        flat_idx <= flat_idx + 1'b1;
                    end
                end
                default: st <= LS_IDLE;
            endcase
        end
    end

endmodule

// File: list.f
+incdir+include
design/ccl_pkg.sv
design/frame_ram.sv
design/centroid_divider.sv
design/label_scan.sv
design/blob_table.sv
design/blob_ranker.sv
design/ccl_top.sv
tests/tb_clock.sv
tests/ccl_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module ccl_tb -o ccl_sim
./obj_dir/ccl_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: include/ccl_ref_model.svh
`ifndef CCL_REF_MODEL_SVH
`define CCL_REF_MODEL_SVH

// 8-connected flood fill, then prune and rank like the DUT
function automatic void ccl_ref_model(
    input  bit frame [ccl_pkg::FRAME_H][ccl_pkg::FRAME_W],
    input  int min_area,
    output int area [3],
    output int cx [3],
    output int cy [3],
    output int count
);
    int lab [ccl_pkg::FRAME_H][ccl_pkg::FRAME_W];
    int stk [ccl_pkg::FRAME_W * ccl_pkg::FRAME_H];
    int sp, n, a, sx, sy, px, py, nx, ny, pos;
    n = 0;
    count = 0;
    for (int i = 0; i < 3; i++) begin
        area[i] = 0;
        cx[i] = 0;
        cy[i] = 0;
    end
    foreach (lab[r, c]) lab[r][c] = 0;
    // blobs found in raster order of their first pixel
    for (int y = 0; y < ccl_pkg::FRAME_H; y++) begin
        for (int x = 0; x < ccl_pkg::FRAME_W; x++) begin
            if (frame[y][x] && lab[y][x] == 0) begin
                n++;
                lab[y][x] = n;
                stk[0] = y * ccl_pkg::FRAME_W + x;
                sp = 1;
                a = 0;
                sx = 0;
                sy = 0;
                while (sp > 0) begin
                    sp--;
                    px = stk[sp] % ccl_pkg::FRAME_W;
                    py = stk[sp] / ccl_pkg::FRAME_W;
                    a++;
                    sx += px;
                    sy += py;
                    for (int dy = -1; dy <= 1; dy++) begin
                        for (int dx = -1; dx <= 1; dx++) begin
                            nx = px + dx;
                            ny = py + dy;
                            if (nx >= 0 && nx < ccl_pkg::FRAME_W && ny >= 0 &&
                                ny < ccl_pkg::FRAME_H && frame[ny][nx] && lab[ny][nx] == 0) begin
                                lab[ny][nx] = n;
                                stk[sp] = ny * ccl_pkg::FRAME_W + nx;
                                sp++;
                            end
                        end
                    end
                end
                // strict compare keeps the earlier blob on ties
                if (a >= min_area && a > area[2]) begin
                    pos = (a > area[0]) ? 0 : (a > area[1]) ? 1 : 2;
                    for (int s = 2; s > pos; s--) begin
                        area[s] = area[s-1];
                        cx[s] = cx[s-1];
                        cy[s] = cy[s-1];
                    end
                    area[pos] = a;
                    cx[pos] = sx / a;
                    cy[pos] = sy / a;
                    if (count < 3) count++;
                end
            end
        end
    end
endfunction

`endif

// File: tests/ccl_tb.sv
`timescale 1ns/1ps

module ccl_tb import ccl_pkg::*; ();

    localparam int MIN_AREA = DEFAULT_MIN_AREA;
    // frames over all tests
    localparam int NUM_FRAMES = 12;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_W * FRAME_H * 40 + 10000;
    localparam int DRIVE_DELAY = 10;

    logic clk, rst_in, new_frame_in, valid_in, mask_in, busy_out, valid_out;
    area_t area_out [3];
    coord_t com_x_out [3];
    coord_t com_y_out [3];
    logic [1:0] blob_count_out;

    // frame under test and what the model says about it
    bit frame [FRAME_H][FRAME_W];
    int exp_area [3];
    int exp_cx [3];
    int exp_cy [3];
    int exp_count;

    int seed = 32'h47ff;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_errors_at_start = 0;
    int frames_sent = 0;
    int frames_checked = 0;
    bit frame_active = 1'b0;
    bit busy_flagged = 1'b0;

    `include "ccl_ref_model.svh"

    tb_clock #(.PERIOD_NS(100)) u_clock (.clk(clk));

    ccl_top #(.MIN_AREA(MIN_AREA)) dut (
        .clk_in         (clk),
        .rst_in         (rst_in),
        .new_frame_in   (new_frame_in),
        .valid_in       (valid_in),
        .mask_in        (mask_in),
        .busy_out       (busy_out),
        .valid_out      (valid_out),
        .area_out       (area_out),
        .com_x_out      (com_x_out),
        .com_y_out      (com_y_out),
        .blob_count_out (blob_count_out)
    );

    // uniform value in 0 .. n-1
    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic clear_frame();
        foreach (frame[r, c]) begin
            frame[r][c] = 1'b0;
        end
    endtask

    // clipped at the frame edge
    task automatic add_rect(input int x0, input int y0, input int w, input int h);
        for (int y = y0; y < y0 + h && y < FRAME_H; y++) begin
            for (int x = x0; x < x0 + w && x < FRAME_W; x++) begin
                frame[y][x] = 1'b1;
            end
        end
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            $display("ERROR t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // one frame in raster order with optional idle gaps
    task automatic send_frame(input bit with_gaps);
        int gap;
        ccl_ref_model(frame, MIN_AREA, exp_area, exp_cx, exp_cy, exp_count);
        busy_flagged = 1'b0;
        new_frame_in = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        new_frame_in = 1'b0;
        frame_active = 1'b1;
        frames_sent++;
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                gap = with_gaps ? rand_below(3) : 0;
                // junk on mask_in while valid_in is low
                repeat (gap) begin
                    valid_in = 1'b0;
                    mask_in = 1'b1;
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                valid_in = 1'b1;
                mask_in = frame[y][x];
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        valid_in = 1'b0;
        mask_in = 1'b0;
        // compare process owns the result check
        wait (frames_checked == frames_sent);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic start_test();
        test_errors_at_start = errors;
    endtask

    task automatic finish_test(input int num, input string name);
        int n;
        n = errors - test_errors_at_start;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", num, name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    // samples on the falling edge away from the drive
    initial begin : compare_results
        forever begin
            @(negedge clk);
            assert (!valid_out || frame_active) else begin
                $display("valid_out pulsed at t=%0t with no frame in flight", $time);
                errors++;
            end
            if (frame_active && valid_out) begin
                compare_value("blob_count_out", exp_count, int'(blob_count_out));
                for (int i = 0; i < 3; i++) begin
                    compare_value($sformatf("area_out[%0d]", i), exp_area[i], int'(area_out[i]));
                    compare_value($sformatf("com_x_out[%0d]", i), exp_cx[i], int'(com_x_out[i]));
                    compare_value($sformatf("com_y_out[%0d]", i), exp_cy[i], int'(com_y_out[i]));
                end
                // pulse lasts one cycle and busy has dropped
                @(negedge clk);
                compare_value("valid_out", 0, int'(valid_out));
                compare_value("busy_out", 0, int'(busy_out));
                frame_active = 1'b0;
                frames_checked++;
            end else if (frame_active && !busy_flagged) begin
                // report a dropped busy once per frame
                compare_value("busy_out", 1, int'(busy_out));
                busy_flagged = (busy_out !== 1'b1);
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the DUT never raised valid_out", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        int n;
        rst_in = 1'b1;
        new_frame_in = 1'b0;
        valid_in = 1'b0;
        mask_in = 1'b0;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst_in = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;

        start_test();
        clear_frame();
        send_frame(1'b0);
        finish_test(1, "empty frame");

        // the 9 pixel square falls off the top three
        start_test();
        clear_frame();
        add_rect(1, 1, 6, 5);
        add_rect(10, 2, 4, 4);
        add_rect(20, 10, 3, 4);
        add_rect(2, 15, 3, 3);
        send_frame(1'b0);
        finish_test(2, "four rectangles");

        start_test();
        clear_frame();
        // U whose two bars only meet on the bottom row
        add_rect(3, 2, 1, 8);
        add_rect(8, 2, 1, 8);
        add_rect(3, 9, 6, 1);
        // V whose arms join through nw and ne at the tip
        for (int i = 0; i < 5; i++) begin
            frame[12 + i][14 + i] = 1'b1;
            frame[12 + i][22 - i] = 1'b1;
        end
        send_frame(1'b0);
        clear_frame();
        // zigzag where every peak takes a fresh label and every valley merges
        for (int x = 1; x < 27; x++) begin
            frame[10 + ((x % 6 > 3) ? x % 6 - 3 : 3 - x % 6)][x] = 1'b1;
        end
        // staircase with steps touching corner to corner
        for (int i = 0; i < 4; i++) begin
            add_rect(2 + 3 * i, 21 - 2 * i, 3, 2);
        end
        send_frame(1'b0);
        finish_test(3, "merge shapes");

        // 7 and 8 pixel blobs around the area limit
        start_test();
        clear_frame();
        add_rect(2, 2, 7, 1);
        add_rect(2, 6, 8, 1);
        add_rect(20, 3, 1, 7);
        add_rect(25, 15, 2, 4);
        send_frame(1'b0);
        finish_test(4, "minimum area");

        // four blobs of 16 where the last in raster order is dropped
        start_test();
        clear_frame();
        add_rect(12, 18, 8, 2);
        add_rect(3, 10, 2, 8);
        add_rect(28, 14, 2, 8);
        add_rect(20, 3, 4, 4);
        send_frame(1'b0);
        finish_test(5, "equal area ties");

        // rectangles plus lone pixels keep the label count low
        start_test();
        for (int t = 0; t < 6; t++) begin
            clear_frame();
            n = 3 + rand_below(6);
            for (int r = 0; r < n; r++) begin
                add_rect(rand_below(FRAME_W), rand_below(FRAME_H), 1 + rand_below(7),
                         1 + rand_below(6));
            end
            n = rand_below(9);
            for (int s = 0; s < n; s++) begin
                frame[rand_below(FRAME_H)][rand_below(FRAME_W)] = 1'b1;
            end
            send_frame(1'b1);
        end
        finish_test(6, "random frames with gaps");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free running, 50/50 duty
    always begin
        #(PERIOD_NS / 2);
        clk = ~clk;
    end

endmodule
